/* verilog/cpuPkg.sv */
// Core package
// Widths, opcodes and decode encodings
`default_nettype none

package cpuPkg;

    localparam int dataWidth    = 16;
    localparam int regAddrWidth = 3;
    localparam int numRegs      = 8;

    // Instruction bits 15 to 11
    typedef enum logic [4:0] {
        opHalt  = 5'b00000,
        opNop   = 5'b00001,
        opJ     = 5'b00100,
        opJal   = 5'b00110,
        opAddi  = 5'b01000,
        opSubi  = 5'b01001,
        opXori  = 5'b01010,
        opAndni = 5'b01011,
        opBeqz  = 5'b01100,
        opBnez  = 5'b01101,
        opSlbi  = 5'b10010,
        opLbi   = 5'b11000,
        opRtype = 5'b11011
    } opcodeE;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluXor,
        aluAndn,
        aluPassB,
        aluSlb,
        aluLink
    } aluOpE;

    typedef enum logic [1:0] {
        brNone,
        brBeqz,
        brBnez,
        brJump
    } branchE;

    // R-format function field in bits 1 to 0
    localparam logic [1:0] funcAdd  = 2'b00;
    localparam logic [1:0] funcSub  = 2'b01;
    localparam logic [1:0] funcXor  = 2'b10;
    localparam logic [1:0] funcAndn = 2'b11;

    // Immediate field size
    localparam logic [1:0] immSize5  = 2'd0;
    localparam logic [1:0] immSize8  = 2'd1;
    localparam logic [1:0] immSize11 = 2'd2;

    // Destination register select
    localparam logic [1:0] dstHigh = 2'd0;
    localparam logic [1:0] dstRd   = 2'd1;
    localparam logic [1:0] dstLink = 2'd2;

endpackage

`default_nettype wire

/* verilog/pipeIf.sv */
// Pipeline stage boundaries
`timescale 1ns/1ps
`default_nettype none

// Fetch to decode
interface ifIdIf import cpuPkg::*; ();
    logic                 valid;
    logic [dataWidth-1:0] instr;
    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] pc2;

    modport source (output valid, instr, pc, pc2);
    modport sink   (input  valid, instr, pc, pc2);
endinterface

// Decode to execute
interface idExIf import cpuPkg::*; ();
    logic                    valid;
    aluOpE                   aluOp;
    logic [dataWidth-1:0]    opA;
    logic [dataWidth-1:0]    opB;
    logic [dataWidth-1:0]    pc2;
    logic [dataWidth-1:0]    target;
    branchE                  branch;
    logic [regAddrWidth-1:0] wrReg;
    logic                    regWrite;
    logic                    halt;

    modport source (
        output valid, aluOp, opA, opB, pc2, target, branch, wrReg, regWrite, halt
    );
    modport sink (
        input  valid, aluOp, opA, opB, pc2, target, branch, wrReg, regWrite, halt
    );
endinterface

`default_nettype wire

/* verilog/fetchStage.sv */
// Fetch stage
`timescale 1ns/1ps
`default_nettype none

module fetchStage import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 stall,
    input  logic                 redirect,
    input  logic                 halted,
    input  logic [dataWidth-1:0] redirectPc,
    input  logic [dataWidth-1:0] instr,
    output logic [dataWidth-1:0] pc,
    ifIdIf.source                ifId
);

    logic [dataWidth-1:0] pcQ;
    logic [dataWidth-1:0] pcPlus2;
    logic                 advance;

    assign pc      = pcQ;
    assign pcPlus2 = pcQ + 16'd2;

    // New instruction enters IF/ID only on a clean step
    assign advance = ~redirect & ~halted & ~stall;

    // PC and IF/ID valid
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcQ        <= '0;
            ifId.valid <= 1'b0;
        end else if (redirect) begin
            // Taken branch or jump wins over a stall
            pcQ        <= redirectPc;
            ifId.valid <= 1'b0;
        end else if (halted) begin
            ifId.valid <= 1'b0;
        end else if (!stall) begin
            pcQ        <= pcPlus2;
            ifId.valid <= 1'b1;
        end
    end

    // IF/ID payload holds while stalled
    always_ff @(posedge clk) begin
        if (advance) begin
            ifId.instr <= instr;
            ifId.pc    <= pcQ;
            ifId.pc2   <= pcPlus2;
        end
    end

endmodule

`default_nettype wire

/* verilog/regFile.sv */
// Register file with write bypass
`timescale 1ns/1ps
`default_nettype none

module regFile import cpuPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [regAddrWidth-1:0] rdAddr1,
    input  logic [regAddrWidth-1:0] rdAddr2,
    output logic [dataWidth-1:0]    rdData1,
    output logic [dataWidth-1:0]    rdData2,
    input  logic                    wrEn,
    input  logic [regAddrWidth-1:0] wrAddr,
    input  logic [dataWidth-1:0]    wrData
);

    logic [dataWidth-1:0] regs [numRegs];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // A read of the register being written sees the new value
    always_comb begin
        if (wrEn && (wrAddr == rdAddr1)) begin
            rdData1 = wrData;
        end else begin
            rdData1 = regs[rdAddr1];
        end
    end

    always_comb begin
        if (wrEn && (wrAddr == rdAddr2)) begin
            rdData2 = wrData;
        end else begin
            rdData2 = regs[rdAddr2];
        end
    end

endmodule

`default_nettype wire

/* verilog/decodeStage.sv */
// Decode stage
// Control decode, register read and ID/EX register
`timescale 1ns/1ps
`default_nettype none

module decodeStage import cpuPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    ifIdIf.sink                     ifId,
    idExIf.source                   idEx,
    input  logic                    wbValid,
    input  logic [regAddrWidth-1:0] wbReg,
    input  logic [dataWidth-1:0]    wbData,
    input  logic                    redirect,
    input  logic                    halted,
    output logic                    stall
);

    opcodeE                  op;
    aluOpE                   aluOp;
    branchE                  branch;
    logic                    regWrite;
    logic                    halt;
    logic [1:0]              immSize;
    logic                    zeroEx;
    logic [1:0]              dstSel;
    logic                    useRs;
    logic                    useRt;
    logic                    aFromRt;
    logic                    bFromImm;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] wrReg;
    logic [dataWidth-1:0]    imm;
    logic [dataWidth-1:0]    rdData1;
    logic [dataWidth-1:0]    rdData2;

    assign op = opcodeE'(ifId.instr[15:11]);
    assign rs = ifId.instr[10:8];
    assign rt = ifId.instr[7:5];

    // Control decode. I-format uses bits 7:5 as source and 10:8 as destination
    always_comb begin
        aluOp    = aluAdd;
        branch   = brNone;
        regWrite = 1'b0;
        halt     = 1'b0;
        immSize  = immSize5;
        zeroEx   = 1'b0;
        dstSel   = dstHigh;
        useRs    = 1'b0;
        useRt    = 1'b0;
        aFromRt  = 1'b0;
        bFromImm = 1'b1;
        case (op)
            opHalt: halt = 1'b1;
            opAddi, opSubi, opXori, opAndni: begin
                regWrite = 1'b1;
                useRt    = 1'b1;
                aFromRt  = 1'b1;
                zeroEx   = (op == opXori) || (op == opAndni);
                case (op)
                    opSubi:  aluOp = aluSub;
                    opXori:  aluOp = aluXor;
                    opAndni: aluOp = aluAndn;
                    default: aluOp = aluAdd;
                endcase
            end
            opLbi: begin
                regWrite = 1'b1;
                immSize  = immSize8;
                aluOp    = aluPassB;
            end
            opSlbi: begin
                regWrite = 1'b1;
                useRs    = 1'b1;
                immSize  = immSize8;
                zeroEx   = 1'b1;
                aluOp    = aluSlb;
            end
            opRtype: begin
                regWrite = 1'b1;
                useRs    = 1'b1;
                useRt    = 1'b1;
                bFromImm = 1'b0;
                dstSel   = dstRd;
                case (ifId.instr[1:0])
                    funcAdd:  aluOp = aluAdd;
                    funcSub:  aluOp = aluSub;
                    funcXor:  aluOp = aluXor;
                    funcAndn: aluOp = aluAndn;
                endcase
            end
            opBeqz, opBnez: begin
                useRs   = 1'b1;
                immSize = immSize8;
                branch  = (op == opBeqz) ? brBeqz : brBnez;
            end
            opJ, opJal: begin
                immSize = immSize11;
                branch  = brJump;
                if (op == opJal) begin
                    regWrite = 1'b1;
                    dstSel   = dstLink;
                    aluOp    = aluLink;
                end
            end
            default: ;
        endcase
    end

    // Immediate extension by field size
    always_comb begin
        case (immSize)
            immSize8: begin
                imm = zeroEx ? {8'h00, ifId.instr[7:0]}
                             : {{8{ifId.instr[7]}}, ifId.instr[7:0]};
            end
            immSize11: begin
                imm = zeroEx ? {5'h00, ifId.instr[10:0]}
                             : {{5{ifId.instr[10]}}, ifId.instr[10:0]};
            end
            default: begin
                imm = zeroEx ? {11'h000, ifId.instr[4:0]}
                             : {{11{ifId.instr[4]}}, ifId.instr[4:0]};
            end
        endcase
    end

    always_comb begin
        case (dstSel)
            dstRd:   wrReg = ifId.instr[4:2];
            dstLink: wrReg = 3'd7;
            default: wrReg = ifId.instr[10:8];
        endcase
    end

    regFile i_regFile (
        .clk     (clk),
        .rstN    (rstN),
        .rdAddr1 (rs),
        .rdAddr2 (rt),
        .rdData1 (rdData1),
        .rdData2 (rdData2),
        .wrEn    (wbValid),
        .wrAddr  (wbReg),
        .wrData  (wbData)
    );

    // RAW on the instruction in execute costs one bubble before the bypass covers it
    assign stall = ifId.valid && idEx.valid && idEx.regWrite &&
                   ((useRs && (rs == idEx.wrReg)) || (useRt && (rt == idEx.wrReg)));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idEx.valid <= 1'b0;
        end else begin
            idEx.valid <= ifId.valid & ~stall & ~redirect & ~halted;
        end
    end

    always_ff @(posedge clk) begin
        idEx.aluOp    <= aluOp;
        idEx.opA      <= aFromRt ? rdData2 : rdData1;
        idEx.opB      <= bFromImm ? imm : rdData2;
        idEx.pc2      <= ifId.pc2;
        // Relative to the following instruction
        idEx.target   <= ifId.pc + 16'd2 + imm;
        idEx.branch   <= branch;
        idEx.wrReg    <= wrReg;
        idEx.regWrite <= regWrite;
        idEx.halt     <= halt;
    end

endmodule

`default_nettype wire

/* verilog/executeStage.sv */
// Execute stage
// ALU, branch resolution and EX/WB register
`timescale 1ns/1ps
`default_nettype none

module executeStage import cpuPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    idExIf.sink                     idEx,
    output logic                    redirect,
    output logic [dataWidth-1:0]    redirectPc,
    output logic                    wbValid,
    output logic [regAddrWidth-1:0] wbReg,
    output logic [dataWidth-1:0]    wbData,
    output logic                    halted
);

    logic                 haltQ;
    logic                 exValid;
    logic                 opAZero;
    logic                 taken;
    logic [dataWidth-1:0] aluResult;

    // Nothing executes once the core has halted
    assign exValid = idEx.valid & ~haltQ;
    assign opAZero = (idEx.opA == '0);

    always_comb begin
        case (idEx.aluOp)
            aluAdd:  aluResult = idEx.opA + idEx.opB;
            aluSub:  aluResult = idEx.opA - idEx.opB;
            aluXor:  aluResult = idEx.opA ^ idEx.opB;
            aluAndn: aluResult = idEx.opA & ~idEx.opB;
            aluSlb:  aluResult = {idEx.opA[7:0], 8'h00} | idEx.opB;
            aluLink: aluResult = idEx.pc2;
            default: aluResult = idEx.opB;
        endcase
    end

    always_comb begin
        case (idEx.branch)
            brBeqz:  taken = opAZero;
            brBnez:  taken = ~opAZero;
            brJump:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect   = exValid & taken;
    assign redirectPc = idEx.target;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= exValid & idEx.regWrite;
        end
    end

    always_ff @(posedge clk) begin
        wbReg  <= idEx.wrReg;
        wbData <= aluResult;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            haltQ <= 1'b0;
        end else if (exValid && idEx.halt) begin
            haltQ <= 1'b1;
        end
    end

    // Rises while HALT is in execute, so the PC freezes at the HALT address plus 4
    assign halted = haltQ | (exValid & idEx.halt);

endmodule

`default_nettype wire

/* verilog/cpuCore.sv */
// Four-stage pipelined core
`timescale 1ns/1ps
`default_nettype none

module cpuCore import cpuPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [dataWidth-1:0]    instr,
    output logic [dataWidth-1:0]    pc,
    output logic                    wbValid,
    output logic [regAddrWidth-1:0] wbReg,
    output logic [dataWidth-1:0]    wbData,
    output logic                    halted
);

    logic                 stall;
    logic                 redirect;
    logic [dataWidth-1:0] redirectPc;

    ifIdIf ifId ();
    idExIf idEx ();

    fetchStage i_fetch (
        .clk        (clk),
        .rstN       (rstN),
        .stall      (stall),
        .redirect   (redirect),
        .halted     (halted),
        .redirectPc (redirectPc),
        .instr      (instr),
        .pc         (pc),
        .ifId       (ifId.source)
    );

    decodeStage i_decode (
        .clk      (clk),
        .rstN     (rstN),
        .ifId     (ifId.sink),
        .idEx     (idEx.source),
        .wbValid  (wbValid),
        .wbReg    (wbReg),
        .wbData   (wbData),
        .redirect (redirect),
        .halted   (halted),
        .stall    (stall)
    );

    executeStage i_execute (
        .clk        (clk),
        .rstN       (rstN),
        .idEx       (idEx.sink),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .wbValid    (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData),
        .halted     (halted)
    );

endmodule

`default_nettype wire

/* sim/cpuCoreTb.sv */
// Testbench for the pipelined core
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb import cpuPkg::*; ();

    localparam int clkHalf      = 2;
    localparam int resetCycles  = 5;
    localparam int settleCycles = 5;
    // Word offsets of the sections in the golden file
    localparam int progBase     = 'h10;
    localparam int wbBase       = 'h80;
    localparam logic [dataWidth-1:0] nopWord = {opNop, 11'h000};

    logic                    clk;
    logic                    rstN;
    logic [dataWidth-1:0]    instr;
    logic [dataWidth-1:0]    pc;
    logic                    wbValid;
    logic [regAddrWidth-1:0] wbReg;
    logic [dataWidth-1:0]    wbData;
    logic                    halted;

    logic [31:0]             golden [0:255];
    int                      progLen;
    int                      wbCount;
    int                      wbSeen;
    logic [dataWidth-1:0]    haltPc;
    logic                    haltSeen;

    cpuCore i_dut (
        .clk     (clk),
        .rstN    (rstN),
        .instr   (instr),
        .pc      (pc),
        .wbValid (wbValid),
        .wbReg   (wbReg),
        .wbData  (wbData),
        .halted  (halted)
    );

    initial begin
        clk = 1'b0;
        forever #clkHalf clk = ~clk;
    end

    task automatic abortRun();
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkWb(
        input int                      index,
        input logic [regAddrWidth-1:0] expReg,
        input logic [regAddrWidth-1:0] actReg,
        input logic [dataWidth-1:0]    expData,
        input logic [dataWidth-1:0]    actData
    );
        if (actReg !== expReg) begin
            $display("ERR wbReg at write-back %0d expected 0x%h actual 0x%h",
                     index, expReg, actReg);
            abortRun();
        end
        if (actData !== expData) begin
            $display("ERR wbData at write-back %0d expected 0x%h actual 0x%h",
                     index, expData, actData);
            abortRun();
        end
    endtask

    task automatic checkHalt(
        input logic [dataWidth-1:0] expPc,
        input logic [dataWidth-1:0] actPc
    );
        if (actPc !== expPc) begin
            $display("ERR pc after halt expected 0x%h actual 0x%h", expPc, actPc);
            abortRun();
        end
    endtask

    // Unused instruction memory words read as NOP
    function automatic logic [dataWidth-1:0] imemRead(input logic [dataWidth-1:0] addr);
        int idx;
        idx = int'(addr[dataWidth-1:1]);
        if (idx < progLen) begin
            return golden[progBase + idx][dataWidth-1:0];
        end
        return nopWord;
    endfunction

    always @(negedge clk) begin
        instr = imemRead(pc);
    end

    // Each write-back is checked against the golden list in program order
    always @(negedge clk) begin
        if (rstN && wbValid) begin
            if (haltSeen) begin
                $display("A write-back to R%0d happened after the core halted", wbReg);
                abortRun();
            end
            if (wbSeen >= wbCount) begin
                $display("Unexpected extra write-back to R%0d, only %0d expected",
                         wbReg, wbCount);
                abortRun();
            end
            checkWb(wbSeen, golden[wbBase + wbSeen][16 +: regAddrWidth], wbReg,
                    golden[wbBase + wbSeen][dataWidth-1:0], wbData);
            wbSeen = wbSeen + 1;
        end
        if (rstN) begin
            haltSeen = haltSeen | halted;
        end
    end

    initial begin
        @(posedge rstN);
        repeat (10 * progLen + 50) @(posedge clk);
        $display("Timeout: the core did not halt within %0d cycles", 10 * progLen + 50);
        abortRun();
    end

    initial begin
        rstN     = 1'b0;
        instr    = nopWord;
        wbSeen   = 0;
        haltSeen = 1'b0;
        $readmemh("sim/cpuCore_golden.txt", golden);
        progLen = int'(golden[0]);
        wbCount = int'(golden[1]);
        haltPc  = golden[2][dataWidth-1:0];
        if (progLen == 0) begin
            $display("The golden file holds no program");
            abortRun();
        end
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;

        while (halted !== 1'b1) @(negedge clk);
        // Let the pipeline drain and make sure pc stays frozen
        repeat (settleCycles) @(negedge clk);
        #1;
        checkHalt(haltPc, pc);
        if (wbSeen == wbCount) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("Missing write-backs: saw %0d of %0d expected", wbSeen, wbCount);
            abortRun();
        end
    end

endmodule

`default_nettype wire

/* sim/cpuCore_golden.txt */
// @000: program length, write-back count, halt PC. @010: program words by address/2.
// @080: expected write-backs in order, register in bits 18:16 and data in bits 15:0.
@000
0000001b
0000000f
00000036
@010
0000c112 // 00 LBI   R1, 0x12
00009134 // 02 SLBI  R1, 0x34
0000c2f0 // 04 LBI   R2, 0xf0
0000435d // 06 ADDI  R3, R2, -3
00005c3f // 08 ANDNI R4, R1, 0x1f
00005571 // 0a XORI  R5, R3, 0x11
00004e24 // 0c SUBI  R6, R1, 4
0000d988 // 0e ADD   R2, R1, R4
0000dacd // 10 SUB   R3, R2, R6
0000dbb2 // 12 XOR   R4, R3, R5
0000dc37 // 14 ANDN  R5, R4, R1
0000c000 // 16 LBI   R0, 0
00006002 // 18 BEQZ  R0, +2 taken
0000c6aa // 1a LBI   R6, 0xaa skipped
00006802 // 1c BNEZ  R0, +2 not taken
000046c1 // 1e ADDI  R6, R6, 1
00006102 // 20 BEQZ  R1, +2 not taken
00006902 // 22 BNEZ  R1, +2 taken
0000c655 // 24 LBI   R6, 0x55 skipped
00002002 // 26 J     +2
0000c677 // 28 LBI   R6, 0x77 skipped
00003004 // 2a JAL   +4
0000c611 // 2c LBI   R6, 0x11 skipped
0000c622 // 2e LBI   R6, 0x22 skipped
0000dfc4 // 30 ADD   R1, R7, R6
00000000 // 32 HALT
0000c299 // 34 LBI   R2, 0x99 never executes
@080
00010012
00011234
0002fff0
0003ffed
00041220
0005fffc
00061230
00022454
00031224
0004edd8
0005edc8
00000000
00061231
0007002c
0001125d

/* cpuCore.f */
verilog/cpuPkg.sv
verilog/pipeIf.sv
verilog/fetchStage.sv
verilog/regFile.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/cpuCore.sv
sim/cpuCoreTb.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -f cpuCore.f \
    --top-module cpuCoreTb -o cpuCoreSim || exit 1
out="$(./obj_dir/cpuCoreSim 2>&1)"
echo "$out"
echo "$out" | grep -qF "PASS: all tests" && echo "Result: passed" \
    || { echo "Result: failed"; exit 1; }
